/* verilog/csr_pkg.sv */
package csr_pkg;

    localparam int CSR_NUM_W  = 14;
    localparam int CSR_DATA_W = 32;

    // csr numbers
    localparam logic [CSR_NUM_W-1:0] CSR_CRMD   = 14'h00;
    localparam logic [CSR_NUM_W-1:0] CSR_PRMD   = 14'h01;
    localparam logic [CSR_NUM_W-1:0] CSR_ECFG   = 14'h04;
    localparam logic [CSR_NUM_W-1:0] CSR_ESTAT  = 14'h05;
    localparam logic [CSR_NUM_W-1:0] CSR_ERA    = 14'h06;
    localparam logic [CSR_NUM_W-1:0] CSR_BADV   = 14'h07;
    localparam logic [CSR_NUM_W-1:0] CSR_EENTRY = 14'h0c;
    localparam logic [CSR_NUM_W-1:0] CSR_SAVE0  = 14'h30; // save1..3 follow
    localparam logic [CSR_NUM_W-1:0] CSR_TID    = 14'h40;
    localparam logic [CSR_NUM_W-1:0] CSR_TCFG   = 14'h41;
    localparam logic [CSR_NUM_W-1:0] CSR_TVAL   = 14'h42;
    localparam logic [CSR_NUM_W-1:0] CSR_TICLR  = 14'h44;

    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam logic [ECODE_W-1:0]    ECODE_ADE     = 6'h08;
    localparam logic [ECODE_W-1:0]    ECODE_ALE     = 6'h09;
    localparam logic [ESUBCODE_W-1:0] ESUBCODE_ADEF = 9'h000; // fetch side of ADE

    localparam int PLV_W         = 2;
    localparam int INT_W         = 13;
    localparam int SW_INT_W      = 2;
    localparam int HW_INT_W      = 8;
    localparam logic [INT_W-1:0] LIE_MASK = 13'h1bff; // bit 10 reserved
    localparam int TIMER_INT_BIT = 11;
    localparam int IPI_INT_BIT   = 12;
    localparam logic [CSR_DATA_W-1:0] TIMER_IDLE = 32'hffff_ffff;

    // field positions
    localparam int CRMD_PLV_LO    = 0;
    localparam int CRMD_PLV_HI    = 1;
    localparam int CRMD_IE        = 2;
    localparam int CRMD_DA        = 3;
    localparam int PRMD_PPLV_LO   = 0;
    localparam int PRMD_PPLV_HI   = 1;
    localparam int PRMD_PIE       = 2;
    localparam int ESTAT_IS_LO    = 0;
    localparam int ESTAT_IS_HI    = 12;
    localparam int ESTAT_ECODE_LO = 16;
    localparam int ESTAT_ECODE_HI = 21;
    localparam int ESTAT_ESUB_LO  = 22;
    localparam int ESTAT_ESUB_HI  = 30;
    localparam int EENTRY_VA_LO   = 6;
    localparam int EENTRY_VA_HI   = 31;
    localparam int TCFG_EN        = 0;
    localparam int TCFG_PERIODIC  = 1;
    localparam int TCFG_INITV_LO  = 2;
    localparam int TCFG_INITV_HI  = 31;
    localparam int TICLR_CLR      = 0;

    // mask selects new bits, the rest keep their old value
    function automatic logic [CSR_DATA_W-1:0] masked_write(
        input logic [CSR_DATA_W-1:0] old_value,
        input logic [CSR_DATA_W-1:0] mask,
        input logic [CSR_DATA_W-1:0] value
    );
        return (mask & value) | (~mask & old_value);
    endfunction

endpackage

/* verilog/csr_exception_state.sv */
`timescale 1ns/10ps

module csr_exception_state (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               csr_we,
    input  logic [csr_pkg::CSR_NUM_W-1:0]      csr_num,
    input  logic [csr_pkg::CSR_DATA_W-1:0]     csr_wmask,
    input  logic [csr_pkg::CSR_DATA_W-1:0]     csr_wvalue,
    input  logic                               wb_ex,
    input  logic                               ertn_flush,
    input  logic [csr_pkg::ECODE_W-1:0]        wb_ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0]     wb_esubcode,
    input  logic [csr_pkg::CSR_DATA_W-1:0]     wb_pc,
    input  logic [csr_pkg::CSR_DATA_W-1:0]     wb_vaddr,
    output logic                               crmd_ie,
    output logic [csr_pkg::CSR_DATA_W-1:0]     ex_entry,
    output logic [csr_pkg::CSR_DATA_W-1:0]     ertn_entry,
    output logic [csr_pkg::CSR_DATA_W-1:0]     rdata
);

    logic [csr_pkg::PLV_W-1:0]      crmd_plv;
    logic [csr_pkg::PLV_W-1:0]      prmd_pplv;
    logic                           prmd_pie;
    logic [csr_pkg::ECODE_W-1:0]    estat_ecode;
    logic [csr_pkg::ESUBCODE_W-1:0] estat_esubcode;
    logic [csr_pkg::CSR_DATA_W-1:0] era;
    logic [csr_pkg::CSR_DATA_W-1:0] badv;
    logic [csr_pkg::EENTRY_VA_HI-csr_pkg::EENTRY_VA_LO:0] eentry_va;

    logic [csr_pkg::CSR_DATA_W-1:0] crmd_word, prmd_word, estat_word, eentry_word;
    logic [csr_pkg::CSR_DATA_W-1:0] crmd_next, prmd_next, era_next, eentry_next;
    logic                           wr_ok;
    logic                           addr_err;

    // writeback events take priority over csr writes
    assign wr_ok = csr_we && !wb_ex && !ertn_flush;

    always_comb begin
        crmd_word = '0;
        crmd_word[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO] = crmd_plv;
        crmd_word[csr_pkg::CRMD_IE] = crmd_ie;
        crmd_word[csr_pkg::CRMD_DA] = 1'b1; // direct address only

        prmd_word = '0;
        prmd_word[csr_pkg::PRMD_PPLV_HI:csr_pkg::PRMD_PPLV_LO] = prmd_pplv;
        prmd_word[csr_pkg::PRMD_PIE] = prmd_pie;

        // IS field comes from csr_interrupt
        estat_word = '0;
        estat_word[csr_pkg::ESTAT_ECODE_HI:csr_pkg::ESTAT_ECODE_LO] = estat_ecode;
        estat_word[csr_pkg::ESTAT_ESUB_HI:csr_pkg::ESTAT_ESUB_LO]   = estat_esubcode;

        eentry_word = '0;
        eentry_word[csr_pkg::EENTRY_VA_HI:csr_pkg::EENTRY_VA_LO] = eentry_va;
    end

    assign crmd_next   = csr_pkg::masked_write(crmd_word, csr_wmask, csr_wvalue);
    assign prmd_next   = csr_pkg::masked_write(prmd_word, csr_wmask, csr_wvalue);
    assign era_next    = csr_pkg::masked_write(era, csr_wmask, csr_wvalue);
    assign eentry_next = csr_pkg::masked_write(eentry_word, csr_wmask, csr_wvalue);

    assign addr_err = wb_ecode == csr_pkg::ECODE_ADE || wb_ecode == csr_pkg::ECODE_ALE;

    always_ff @(posedge clk) begin
        if (reset) begin
            crmd_plv       <= '0;
            crmd_ie        <= 1'b0;
            prmd_pplv      <= '0;
            prmd_pie       <= 1'b0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
        end else if (wb_ex) begin
            prmd_pplv      <= crmd_plv;    // save mode, drop to plv0 with ints off
            prmd_pie       <= crmd_ie;
            crmd_plv       <= '0;
            crmd_ie        <= 1'b0;
            estat_ecode    <= wb_ecode;
            estat_esubcode <= wb_esubcode;
        end else if (ertn_flush) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_ok) begin
            if (csr_num == csr_pkg::CSR_CRMD) begin
                crmd_plv <= crmd_next[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO];
                crmd_ie  <= crmd_next[csr_pkg::CRMD_IE];
            end
            if (csr_num == csr_pkg::CSR_PRMD) begin
                prmd_pplv <= prmd_next[csr_pkg::PRMD_PPLV_HI:csr_pkg::PRMD_PPLV_LO];
                prmd_pie  <= prmd_next[csr_pkg::PRMD_PIE];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_ex)
            era <= wb_pc;
        else if (wr_ok && csr_num == csr_pkg::CSR_ERA)
            era <= era_next;

        if (wb_ex && addr_err) begin
            // fetch errors report the pc itself
            if (wb_ecode == csr_pkg::ECODE_ADE && wb_esubcode == csr_pkg::ESUBCODE_ADEF)
                badv <= wb_pc;
            else
                badv <= wb_vaddr;
        end

        if (wr_ok && csr_num == csr_pkg::CSR_EENTRY)
            eentry_va <= eentry_next[csr_pkg::EENTRY_VA_HI:csr_pkg::EENTRY_VA_LO];
    end

    always_comb begin
        case (csr_num)
            csr_pkg::CSR_CRMD:   rdata = crmd_word;
            csr_pkg::CSR_PRMD:   rdata = prmd_word;
            csr_pkg::CSR_ESTAT:  rdata = estat_word;
            csr_pkg::CSR_ERA:    rdata = era;
            csr_pkg::CSR_BADV:   rdata = badv;
            csr_pkg::CSR_EENTRY: rdata = eentry_word;
            default:             rdata = '0;
        endcase
    end

    assign ex_entry   = eentry_word;
    assign ertn_entry = era;

    // writeback never raises an exception and a return together
    assert property (@(posedge clk) disable iff (reset) !(wb_ex && ertn_flush));

endmodule

/* verilog/csr_interrupt.sv */
`timescale 1ns/10ps

module csr_interrupt (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             csr_we,
    input  logic [csr_pkg::CSR_NUM_W-1:0]    csr_num,
    input  logic [csr_pkg::CSR_DATA_W-1:0]   csr_wmask,
    input  logic [csr_pkg::CSR_DATA_W-1:0]   csr_wvalue,
    input  logic [csr_pkg::HW_INT_W-1:0]     hw_int,
    input  logic                             ipi_int,
    input  logic                             timer_int,
    input  logic                             crmd_ie,
    output logic                             has_int,
    output logic [csr_pkg::CSR_DATA_W-1:0]   rdata
);

    logic [csr_pkg::INT_W-1:0]      lie;
    logic [csr_pkg::SW_INT_W-1:0]   is_sw;
    logic [csr_pkg::HW_INT_W-1:0]   is_hw;
    logic                           is_ipi;
    logic [csr_pkg::INT_W-1:0]      is_vec;
    logic [csr_pkg::CSR_DATA_W-1:0] ecfg_word, estat_word, ecfg_next, estat_next;

    always_comb begin
        is_vec = '0;   // bit 10 unused
        is_vec[csr_pkg::SW_INT_W-1:0] = is_sw;
        is_vec[csr_pkg::SW_INT_W +: csr_pkg::HW_INT_W] = is_hw;
        is_vec[csr_pkg::TIMER_INT_BIT] = timer_int;
        is_vec[csr_pkg::IPI_INT_BIT]   = is_ipi;

        ecfg_word = '0;
        ecfg_word[csr_pkg::INT_W-1:0] = lie;
        estat_word = '0;
        estat_word[csr_pkg::ESTAT_IS_HI:csr_pkg::ESTAT_IS_LO] = is_vec;
    end

    assign ecfg_next  = csr_pkg::masked_write(ecfg_word, csr_wmask, csr_wvalue);
    assign estat_next = csr_pkg::masked_write(estat_word, csr_wmask, csr_wvalue);

    always_ff @(posedge clk) begin
        if (reset) begin
            lie    <= '0;
            is_sw  <= '0;
            is_hw  <= '0;
            is_ipi <= 1'b0;
        end else begin
            if (csr_we && csr_num == csr_pkg::CSR_ECFG)
                lie <= ecfg_next[csr_pkg::INT_W-1:0] & csr_pkg::LIE_MASK;
            if (csr_we && csr_num == csr_pkg::CSR_ESTAT)
                is_sw <= estat_next[csr_pkg::ESTAT_IS_LO +: csr_pkg::SW_INT_W]; // sw bits only
            is_hw  <= hw_int;
            is_ipi <= ipi_int;
        end
    end

    // ipi bit is not part of the request
    assign has_int = crmd_ie &
        (|(is_vec[csr_pkg::TIMER_INT_BIT:0] & lie[csr_pkg::TIMER_INT_BIT:0]));

    assign rdata = csr_num == csr_pkg::CSR_ECFG  ? ecfg_word  :
                   csr_num == csr_pkg::CSR_ESTAT ? estat_word : '0;

    assert property (@(posedge clk) disable iff (reset) (lie & ~csr_pkg::LIE_MASK) == '0);

endmodule

/* verilog/csr_timer.sv */
`timescale 1ns/10ps

module csr_timer (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             csr_we,
    input  logic [csr_pkg::CSR_NUM_W-1:0]    csr_num,
    input  logic [csr_pkg::CSR_DATA_W-1:0]   csr_wmask,
    input  logic [csr_pkg::CSR_DATA_W-1:0]   csr_wvalue,
    output logic                             timer_int,
    output logic [csr_pkg::CSR_DATA_W-1:0]   rdata
);

    logic [csr_pkg::CSR_DATA_W-1:0] tid;
    logic                           tcfg_en;
    logic                           tcfg_periodic;
    logic [csr_pkg::TCFG_INITV_HI-csr_pkg::TCFG_INITV_LO:0] tcfg_initval;
    logic [csr_pkg::CSR_DATA_W-1:0] timer_cnt;

    logic [csr_pkg::CSR_DATA_W-1:0] tcfg_word, tcfg_next, tid_next;
    logic                           tcfg_wr;
    logic                           ticlr_hit;

    always_comb begin
        tcfg_word = '0;
        tcfg_word[csr_pkg::TCFG_EN]       = tcfg_en;
        tcfg_word[csr_pkg::TCFG_PERIODIC] = tcfg_periodic;
        tcfg_word[csr_pkg::TCFG_INITV_HI:csr_pkg::TCFG_INITV_LO] = tcfg_initval;
    end

    assign tcfg_wr   = csr_we && csr_num == csr_pkg::CSR_TCFG;
    assign tcfg_next = csr_pkg::masked_write(tcfg_word, csr_wmask, csr_wvalue);
    assign tid_next  = csr_pkg::masked_write(tid, csr_wmask, csr_wvalue);
    assign ticlr_hit = csr_we && csr_num == csr_pkg::CSR_TICLR &&
                       csr_wmask[csr_pkg::TICLR_CLR] && csr_wvalue[csr_pkg::TICLR_CLR];

    always_ff @(posedge clk) begin
        if (reset) begin
            tid           <= '0;
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else begin
            if (csr_we && csr_num == csr_pkg::CSR_TID)
                tid <= tid_next;
            if (tcfg_wr) begin
                tcfg_en       <= tcfg_next[csr_pkg::TCFG_EN];
                tcfg_periodic <= tcfg_next[csr_pkg::TCFG_PERIODIC];
                tcfg_initval  <= tcfg_next[csr_pkg::TCFG_INITV_HI:csr_pkg::TCFG_INITV_LO];
            end
        end
    end

    // countdown, stops at idle unless periodic reloads at zero
    always_ff @(posedge clk) begin
        if (reset)
            timer_cnt <= csr_pkg::TIMER_IDLE;
        else if (tcfg_wr && tcfg_next[csr_pkg::TCFG_EN])
            timer_cnt <= {tcfg_next[csr_pkg::TCFG_INITV_HI:csr_pkg::TCFG_INITV_LO], 2'b00};
        else if (tcfg_en && timer_cnt != csr_pkg::TIMER_IDLE) begin
            if (timer_cnt == '0 && tcfg_periodic)
                timer_cnt <= {tcfg_initval, 2'b00};
            else
                timer_cnt <= timer_cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            timer_int <= 1'b0;
        else if (timer_cnt == '0)
            timer_int <= 1'b1;   // set beats clear
        else if (ticlr_hit)
            timer_int <= 1'b0;
    end

    always_comb begin
        case (csr_num)
            csr_pkg::CSR_TID:   rdata = tid;
            csr_pkg::CSR_TCFG:  rdata = tcfg_word;
            csr_pkg::CSR_TVAL:  rdata = timer_cnt;
            csr_pkg::CSR_TICLR: rdata = '0;      // write-only clear
            default:            rdata = '0;
        endcase
    end

    // a stopped timer only moves when TCFG is written
    assert property (@(posedge clk) disable iff (reset)
        (!tcfg_en && !tcfg_wr) |=> $stable(timer_cnt));

endmodule

/* verilog/csr_save_bank.sv */
`timescale 1ns/10ps

module csr_save_bank (
    input  logic                             clk,
    input  logic                             csr_we,
    input  logic [csr_pkg::CSR_NUM_W-1:0]    csr_num,
    input  logic [csr_pkg::CSR_DATA_W-1:0]   csr_wmask,
    input  logic [csr_pkg::CSR_DATA_W-1:0]   csr_wvalue,
    output logic [csr_pkg::CSR_DATA_W-1:0]   rdata
);

    logic [csr_pkg::CSR_DATA_W-1:0] save_mem [4];
    logic [1:0]                     save_idx;
    logic                           save_hit;
    logic [csr_pkg::CSR_DATA_W-1:0] save_next;

    // SAVE0..3 share the upper number bits
    assign save_hit = (csr_num >> 2) == (csr_pkg::CSR_SAVE0 >> 2);
    assign save_idx = csr_num[1:0];

    assign save_next = csr_pkg::masked_write(save_mem[save_idx], csr_wmask, csr_wvalue);

    always_ff @(posedge clk) begin
        if (csr_we && save_hit)
            save_mem[save_idx] <= save_next;
    end

    assign rdata = save_hit ? save_mem[save_idx] : '0;

endmodule

/* verilog/csr_file.sv */
`timescale 1ns/10ps

module csr_file (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [csr_pkg::CSR_NUM_W-1:0]    csr_num,
    input  logic                             csr_we,
    input  logic [csr_pkg::CSR_DATA_W-1:0]   csr_wmask,
    input  logic [csr_pkg::CSR_DATA_W-1:0]   csr_wvalue,
    input  logic                             wb_ex,
    input  logic                             ertn_flush,
    input  logic [csr_pkg::ECODE_W-1:0]      wb_ecode,
    input  logic [csr_pkg::ESUBCODE_W-1:0]   wb_esubcode,
    input  logic [csr_pkg::CSR_DATA_W-1:0]   wb_pc,
    input  logic [csr_pkg::CSR_DATA_W-1:0]   wb_vaddr,
    input  logic [csr_pkg::HW_INT_W-1:0]     hw_int,
    input  logic                             ipi_int,
    output logic [csr_pkg::CSR_DATA_W-1:0]   csr_rvalue,
    output logic                             has_int,
    output logic [csr_pkg::CSR_DATA_W-1:0]   ex_entry,
    output logic [csr_pkg::CSR_DATA_W-1:0]   ertn_entry
);

    logic                           crmd_ie;
    logic                           timer_int;
    logic [csr_pkg::CSR_DATA_W-1:0] exc_rdata;
    logic [csr_pkg::CSR_DATA_W-1:0] int_rdata;
    logic [csr_pkg::CSR_DATA_W-1:0] tmr_rdata;
    logic [csr_pkg::CSR_DATA_W-1:0] save_rdata;

    csr_exception_state u_exception_state (
        .clk         (clk),
        .reset       (reset),
        .csr_we      (csr_we),
        .csr_num     (csr_num),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .ertn_flush  (ertn_flush),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .crmd_ie     (crmd_ie),
        .ex_entry    (ex_entry),
        .ertn_entry  (ertn_entry),
        .rdata       (exc_rdata)
    );

    csr_interrupt u_interrupt (
        .clk        (clk),
        .reset      (reset),
        .csr_we     (csr_we),
        .csr_num    (csr_num),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .hw_int     (hw_int),
        .ipi_int    (ipi_int),
        .timer_int  (timer_int),
        .crmd_ie    (crmd_ie),
        .has_int    (has_int),
        .rdata      (int_rdata)
    );

    csr_timer u_timer (
        .clk        (clk),
        .reset      (reset),
        .csr_we     (csr_we),
        .csr_num    (csr_num),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .timer_int  (timer_int),
        .rdata      (tmr_rdata)
    );

    csr_save_bank u_save_bank (
        .clk        (clk),
        .csr_we     (csr_we),
        .csr_num    (csr_num),
        .csr_wmask  (csr_wmask),
        .csr_wvalue (csr_wvalue),
        .rdata      (save_rdata)
    );

    // blocks return zero for numbers they do not own, ESTAT is split
    assign csr_rvalue = exc_rdata | int_rdata | tmr_rdata | save_rdata;

endmodule

/* tb/csr_file_tb_table.svh */
// each row holds op, csr number, random mode (1 full mask, 2 random mask), mask,
// value, ecode, esubcode and expected bits
// EX rows take value as pc and mask as vaddr
localparam int NUM_ROWS = 77;
localparam row_t TABLE [NUM_ROWS] = '{
    // reset values
    '{OP_RD,    14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h04, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h42, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'hffff_ffff},
    '{OP_HAS,   14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    // fill registers without reset then apply masked writes
    '{OP_WR,    14'h30, 2'd1, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h31, 2'd1, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h32, 2'd1, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h33, 2'd1, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h06, 2'd1, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h0c, 2'd1, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h30, 2'd2, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h31, 2'd2, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h32, 2'd2, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h33, 2'd2, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h30, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h31, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h32, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h33, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h0c, 2'd2, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h06, 2'd2, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h01, 2'd2, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h40, 2'd2, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h04, 2'd2, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h0c, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h06, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h01, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h40, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h04, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_ENTRY, 14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    // alignment error then fetch address error and return
    '{OP_WR,    14'h00, 2'd0, 32'hffff_ffff, 32'h7, 6'h0, 9'h0, 32'h0},
    '{OP_EX,    14'h00, 2'd0, 32'h0000_2003, 32'h1c00_0100, 6'h09, 9'h0, 32'h0},
    '{OP_RD,    14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h01, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h05, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h06, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h07, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_ENTRY, 14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h00, 2'd0, 32'hffff_ffff, 32'h7, 6'h0, 9'h0, 32'h0},
    '{OP_EX,    14'h00, 2'd0, 32'h0000_5555, 32'h1c00_0204, 6'h08, 9'h0, 32'h0},
    '{OP_RD,    14'h07, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h05, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_ERTN,  14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_ENTRY, 14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    // interrupt request from a software bit then hardware line 2 (IS bit 4)
    '{OP_WR,    14'h04, 2'd0, 32'hffff_ffff, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_HAS,   14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h05, 2'd0, 32'h3, 32'h1, 6'h0, 9'h0, 32'h0},
    '{OP_HAS,   14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h04, 2'd0, 32'hffff_ffff, 32'h1, 6'h0, 9'h0, 32'h0},
    '{OP_HAS,   14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h1},
    '{OP_WR,    14'h00, 2'd0, 32'h4, 32'h0, 6'h0, 9'h0, 32'h0},   // ie off
    '{OP_HAS,   14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h00, 2'd0, 32'h4, 32'h4, 6'h0, 9'h0, 32'h0},   // ie back on
    '{OP_WR,    14'h05, 2'd0, 32'h3, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_HAS,   14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_INT,   14'h00, 2'd0, 32'h0, 32'h4, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h05, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h10},
    '{OP_HAS,   14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_WR,    14'h04, 2'd0, 32'hffff_ffff, 32'h10, 6'h0, 9'h0, 32'h0},
    '{OP_HAS,   14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h1},
    '{OP_INT,   14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_HAS,   14'h00, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    // one-shot timer with InitVal 3
    '{OP_WR,    14'h41, 2'd0, 32'hffff_ffff, 32'hd, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h42, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'hc},
    '{OP_IDLE,  14'h00, 2'd0, 32'h0, 32'd11, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h42, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h05, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h800},
    '{OP_RD,    14'h42, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'hffff_ffff},
    '{OP_WR,    14'h44, 2'd0, 32'h1, 32'h1, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h05, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    // periodic timer with InitVal 2
    '{OP_WR,    14'h41, 2'd0, 32'hffff_ffff, 32'hb, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h42, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h8},
    '{OP_IDLE,  14'h00, 2'd0, 32'h0, 32'd7, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h42, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h0},
    '{OP_RD,    14'h05, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h800},
    '{OP_RD,    14'h42, 2'd0, 32'h0, 32'h0, 6'h0, 9'h0, 32'h7},
    '{OP_WR,    14'h41, 2'd0, 32'h1, 32'h0, 6'h0, 9'h0, 32'h0}
};

/* tb/csr_file_tb.sv */
`timescale 1ns/10ps

module csr_file_tb;

    typedef struct packed {
        logic [3:0]  op;
        logic [13:0] num;
        logic [1:0]  rnd;
        logic [31:0] mask;
        logic [31:0] value;
        logic [5:0]  ecode;
        logic [8:0]  esub;
        logic [31:0] exp_val;
    } row_t;

    localparam logic [3:0] OP_WR    = 4'd0;
    localparam logic [3:0] OP_RD    = 4'd1;
    localparam logic [3:0] OP_EX    = 4'd2;
    localparam logic [3:0] OP_ERTN  = 4'd3;
    localparam logic [3:0] OP_IDLE  = 4'd4;
    localparam logic [3:0] OP_INT   = 4'd5;
    localparam logic [3:0] OP_HAS   = 4'd6;
    localparam logic [3:0] OP_ENTRY = 4'd7;

    `include "csr_file_tb_table.svh"

    logic        clk;
    logic        reset;
    logic [13:0] csr_num;
    logic        csr_we;
    logic [31:0] csr_wmask;
    logic [31:0] csr_wvalue;
    logic        wb_ex;
    logic        ertn_flush;
    logic [5:0]  wb_ecode;
    logic [8:0]  wb_esubcode;
    logic [31:0] wb_pc;
    logic [31:0] wb_vaddr;
    logic [7:0]  hw_int;
    logic        ipi_int;
    logic [31:0] csr_rvalue;
    logic        has_int;
    logic [31:0] ex_entry;
    logic [31:0] ertn_entry;

    logic [31:0] lfsr_state;
    logic [31:0] model [0:127];   // expected read value per csr number

    csr_file DUT (
        .clk         (clk),
        .reset       (reset),
        .csr_num     (csr_num),
        .csr_we      (csr_we),
        .csr_wmask   (csr_wmask),
        .csr_wvalue  (csr_wvalue),
        .wb_ex       (wb_ex),
        .ertn_flush  (ertn_flush),
        .wb_ecode    (wb_ecode),
        .wb_esubcode (wb_esubcode),
        .wb_pc       (wb_pc),
        .wb_vaddr    (wb_vaddr),
        .hw_int      (hw_int),
        .ipi_int     (ipi_int),
        .csr_rvalue  (csr_rvalue),
        .has_int     (has_int),
        .ex_entry    (ex_entry),
        .ertn_entry  (ertn_entry)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(NUM_ROWS * 64 * 4);
        $display("timeout, the table did not finish in time");
        $display("Test FAILED");
        $fatal(1);
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand32();
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < 32; b++)
            r = {r[30:0], lfsr_bit()};
        return r;
    endfunction

    // bits that software can change
    function automatic logic [31:0] writable_bits(input logic [13:0] num);
        case (num)
            14'h00, 14'h01:                 return 32'h0000_0007;
            14'h04:                         return 32'h0000_1bff;
            14'h0c:                         return 32'hffff_ffc0;
            14'h06, 14'h30, 14'h31, 14'h32,
            14'h33, 14'h40, 14'h41:         return 32'hffff_ffff;
            default:                        return 32'h0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic apply_row(input row_t row);
        logic [31:0] m;
        logic [31:0] v;
        logic [31:0] wb;
        logic [6:0]  idx;
        idx = row.num[6:0];
        case (row.op)
            OP_WR: begin
                m = row.mask;
                v = row.value;
                if (row.rnd == 2'd1) begin
                    m = 32'hffff_ffff;
                    v = rand32();
                end else if (row.rnd == 2'd2) begin
                    m = rand32();
                    v = rand32();
                end
                csr_num    = row.num;
                csr_we     = 1'b1;
                csr_wmask  = m;
                csr_wvalue = v;
                wb = m & writable_bits(row.num);
                model[idx] = (model[idx] & ~wb) | (v & wb);
            end
            OP_EX: begin
                wb_ex       = 1'b1;
                wb_ecode    = row.ecode;
                wb_esubcode = row.esub;
                wb_pc       = row.value;
                wb_vaddr    = row.mask;
                model[7'h01] = model[7'h00] & 32'h7;
                model[7'h00] = model[7'h00] & ~32'h7;
                model[7'h05] = {1'b0, row.esub, row.ecode, 16'h0};
                model[7'h06] = row.value;
                if (row.ecode == 6'h08 && row.esub == 9'h0)
                    model[7'h07] = row.value;
                else if (row.ecode == 6'h08 || row.ecode == 6'h09)
                    model[7'h07] = row.mask;
            end
            OP_ERTN: begin
                ertn_flush = 1'b1;
                model[7'h00] = (model[7'h00] & ~32'h7) | (model[7'h01] & 32'h7);
            end
            OP_INT: begin
                hw_int  = row.value[7:0];
                ipi_int = row.value[8];
            end
            OP_RD: csr_num = row.num;
            default: ;
        endcase
        #1;
        if (row.op == OP_RD)
            check_value($sformatf("csr_rvalue[%h]", row.num), csr_rvalue,
                        model[idx] | row.exp_val);
        if (row.op == OP_HAS)
            check_value("has_int", {31'b0, has_int}, {31'b0, row.exp_val[0]});
        if (row.op == OP_ENTRY) begin
            check_value("ex_entry", ex_entry, model[7'h0c]);
            check_value("ertn_entry", ertn_entry, model[7'h06]);
        end
        if (row.op == OP_IDLE && row.value > 1)
            repeat (row.value - 1) @(posedge clk);
        @(posedge clk);
        #1;
        csr_we     = 1'b0;
        wb_ex      = 1'b0;
        ertn_flush = 1'b0;
    endtask

    initial begin
        lfsr_state  = 32'h96c4_8967;
        reset       = 1'b1;
        csr_num     = '0;
        csr_we      = 1'b0;
        csr_wmask   = '0;
        csr_wvalue  = '0;
        wb_ex       = 1'b0;
        ertn_flush  = 1'b0;
        wb_ecode    = '0;
        wb_esubcode = '0;
        wb_pc       = '0;
        wb_vaddr    = '0;
        hw_int      = '0;
        ipi_int     = 1'b0;
        for (int i = 0; i < 128; i++)
            model[i] = '0;
        model[7'h00] = 32'h8;   // DA set out of reset
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < NUM_ROWS; i++)
            apply_row(TABLE[i]);
        $display("Test OK");
        $finish;
    end

endmodule

/* csr_file.f */
+incdir+tb
verilog/csr_pkg.sv
verilog/csr_exception_state.sv
verilog/csr_interrupt.sv
verilog/csr_timer.sv
verilog/csr_save_bank.sv
verilog/csr_file.sv
tb/csr_file_tb.sv

/* Makefile */
SRCS = $(wildcard verilog/*.sv) tb/csr_file_tb.sv tb/csr_file_tb_table.svh

.PHONY: all run clean

all: run

obj_dir/Vcsr_file_tb: csr_file.f $(SRCS)
	verilator --binary --timing --assert -f csr_file.f --top-module csr_file_tb

run: obj_dir/Vcsr_file_tb
	-./obj_dir/Vcsr_file_tb > sim.log 2>&1
	cat sim.log
	! grep -q "Test FAILED" sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
